/* hdl/frame_pkg.sv */
`default_nettype none

package frame_pkg;

    // ------------------------------
    // Frame bytes
    // ------------------------------
    localparam logic [7:0] SOF_DEVICE_TO_HOST = 8'h5A;  // Device to host start of frame
    localparam logic [7:0] CMD_RESET          = 8'hFF;  // RESET echo, frame ends after CMD

    // Read statuses that still carry address and data
    localparam logic [7:0] STATUS_OK      = 8'h00;
    localparam logic [7:0] STATUS_OK_ALT0 = 8'h40;
    localparam logic [7:0] STATUS_OK_ALT1 = 8'h80;

    // ------------------------------
    // Sizes
    // ------------------------------
    localparam int MAX_DATA_BYTES = 64;  // Response buffer depth
    localparam int DATA_COUNT_W   = 7;   // Holds 0..64
    localparam int ADDR_BYTES     = 4;   // Address echo, LSB first on the wire

    // CRC-8, MSB first, init 0x00, no final xor
    localparam logic [7:0] CRC_POLY = 8'h07;

    // ------------------------------
    // Command echo views
    // ------------------------------
    typedef struct packed {
        logic       is_read;  // Bit 7 set for read commands
        logic [6:0] opcode;   // Remaining command bits
    } cmd_fields_t;

    // Same byte seen as raw code or as direction plus opcode
    typedef union packed {
        logic [7:0]  raw;     // Compared against CMD_RESET
        cmd_fields_t fields;  // Read or write decode
    } cmd_echo_t;

endpackage

`default_nettype wire

/* hdl/request_capture.sv */
`default_nettype none

module request_capture (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            soft_reset_request,
    input  logic                            build_response,
    input  logic                            busy,                // Sequencer not idle
    input  logic [7:0]                      status_code,
    input  frame_pkg::cmd_echo_t            cmd_echo,
    input  logic [8*frame_pkg::ADDR_BYTES-1:0] addr_echo,
    input  logic [7:0]                      response_data [0:frame_pkg::MAX_DATA_BYTES-1],
    input  logic [frame_pkg::DATA_COUNT_W-1:0] response_data_count,
    input  logic [frame_pkg::DATA_COUNT_W-1:0] data_index,    // From sequencer
    output logic                            frame_start,         // One cycle after capture
    output logic [7:0]                      status_q,
    output frame_pkg::cmd_echo_t            cmd_q,
    output logic [8*frame_pkg::ADDR_BYTES-1:0] addr_q,
    output logic [frame_pkg::DATA_COUNT_W-1:0] count_q,
    output logic [7:0]                      data_byte            // Buffered byte at data_index
);

    import frame_pkg::*;

    logic       build_prev;                   // build_response at previous edge
    logic       capture;                      // Accept a new request this edge
    logic [7:0] data_buf [0:MAX_DATA_BYTES-1];

    // Rising edge while idle; frame_start covers the cycle before busy rises
    assign capture = build_response && !build_prev && !busy && !frame_start;

    // ------------------------------
    // Request fields
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || soft_reset_request) begin
            build_prev  <= 1'b0;
            frame_start <= 1'b0;
            status_q    <= '0;
            cmd_q       <= '0;
            addr_q      <= '0;
            count_q     <= '0;
        end else begin
            build_prev  <= build_response;
            frame_start <= capture;           // Sequencer leaves idle on this
            if (capture) begin
                status_q <= status_code;
                cmd_q    <= cmd_echo;
                addr_q   <= addr_echo;
                // Count above buffer depth is clipped, not rejected
                if (response_data_count > DATA_COUNT_W'(MAX_DATA_BYTES)) begin
                    count_q <= DATA_COUNT_W'(MAX_DATA_BYTES);
                end else begin
                    count_q <= response_data_count;
                end
            end
        end
    end

    // ------------------------------
    // Data buffer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || soft_reset_request) begin
            for (int i = 0; i < MAX_DATA_BYTES; i++) begin
                data_buf[i] <= '0;
            end
        end else if (capture) begin
            // Whole buffer copied, only count_q bytes are ever read
            for (int i = 0; i < MAX_DATA_BYTES; i++) begin
                data_buf[i] <= response_data[i];
            end
        end
    end

    // Index reaches MAX_DATA_BYTES after the last byte of a full buffer
    always_comb begin
        if (data_index < DATA_COUNT_W'(MAX_DATA_BYTES)) begin
            data_byte = data_buf[data_index[DATA_COUNT_W-2:0]];
        end else begin
            data_byte = 8'h00;
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_sequencer.sv */
`default_nettype none

module frame_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            soft_reset_request,
    input  logic                            frame_start,
    input  logic [7:0]                      status_q,
    input  frame_pkg::cmd_echo_t            cmd_q,
    input  logic [8*frame_pkg::ADDR_BYTES-1:0] addr_q,
    input  logic [frame_pkg::DATA_COUNT_W-1:0] count_q,
    input  logic [7:0]                      data_byte,
    input  logic                            tx_fifo_full,
    output logic                            busy,
    output logic [frame_pkg::DATA_COUNT_W-1:0] data_index,
    output logic                            byte_valid,   // Byte accepted this cycle
    output logic [7:0]                      byte_data,
    output logic                            crc_include,  // Fold byte into CRC
    output logic                            crc_send,     // Emit CRC register instead
    output logic                            crc_clear     // Held while idle
);

    import frame_pkg::*;

    typedef enum logic [3:0] {
        IDLE,
        SOF,
        STATUS,
        CMD,
        ADDR,
        DATA,
        CRC,
        DONE,
        GAP
    } seq_state_t;

    seq_state_t state, state_next;

    logic [1:0] addr_cnt;  // Address byte being sent, LSB first
    logic       read_ok;   // Read with a success status

    assign read_ok = (status_q == STATUS_OK) ||
                     (status_q == STATUS_OK_ALT0) ||
                     (status_q == STATUS_OK_ALT1);

    assign busy = (state != IDLE);

    // ------------------------------
    // Byte selection and next state
    // ------------------------------
    always_comb begin
        state_next  = state;
        byte_valid  = 1'b0;
        byte_data   = 8'h00;
        crc_include = 1'b0;
        crc_send    = 1'b0;
        crc_clear   = 1'b0;

        case (state)
            IDLE: begin
                crc_clear = 1'b1;                 // Fresh CRC for every frame
                if (frame_start) begin
                    state_next = SOF;
                end
            end
            SOF: begin
                if (!tx_fifo_full) begin
                    byte_valid = 1'b1;
                    byte_data  = SOF_DEVICE_TO_HOST;  // Not part of the CRC
                    state_next = STATUS;
                end
            end
            STATUS: begin
                if (!tx_fifo_full) begin
                    byte_valid  = 1'b1;
                    byte_data   = status_q;
                    crc_include = 1'b1;
                    state_next  = CMD;
                end
            end
            CMD: begin
                if (!tx_fifo_full) begin
                    byte_valid  = 1'b1;
                    byte_data   = cmd_q.raw;
                    crc_include = 1'b1;
                    // Frame form decided here
                    if (cmd_q.raw == CMD_RESET) begin
                        state_next = IDLE;        // No CRC, no completion
                    end else if (cmd_q.fields.is_read && read_ok) begin
                        state_next = ADDR;
                    end else begin
                        state_next = CRC;         // Write ack or read error
                    end
                end
            end
            ADDR: begin
                if (!tx_fifo_full) begin
                    byte_valid  = 1'b1;
                    byte_data   = addr_q[{addr_cnt, 3'b000} +: 8];
                    crc_include = 1'b1;
                    if (addr_cnt == 2'(ADDR_BYTES - 1)) begin
                        state_next = (count_q == '0) ? CRC : DATA;  // Empty read skips DATA
                    end
                end
            end
            DATA: begin
                if (!tx_fifo_full) begin
                    byte_valid  = 1'b1;
                    byte_data   = data_byte;
                    crc_include = 1'b1;
                    if (data_index + 1'b1 == count_q) begin
                        state_next = CRC;
                    end
                end
            end
            CRC: begin
                if (!tx_fifo_full) begin
                    byte_valid = 1'b1;
                    crc_send   = 1'b1;            // Emitter substitutes its register
                    state_next = DONE;
                end
            end
            DONE:    state_next = GAP;            // Completion registered at end of this
            GAP:     state_next = IDLE;           // Spacing between frames
            default: state_next = IDLE;
        endcase
    end

    // ------------------------------
    // State and byte counters
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || soft_reset_request) begin
            state      <= IDLE;
            addr_cnt   <= '0;
            data_index <= '0;
        end else begin
            state <= state_next;
            if (state == IDLE) begin
                addr_cnt   <= '0;
                data_index <= '0;
            end else begin
                if (state == ADDR && byte_valid) addr_cnt <= addr_cnt + 1'b1;
                if (state == DATA && byte_valid) data_index <= data_index + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_emitter.sv */
`default_nettype none

module frame_emitter (
    input  logic       clk,
    input  logic       rst,
    input  logic       soft_reset_request,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       crc_include,
    input  logic       crc_send,
    input  logic       crc_clear,
    output logic [7:0] tx_fifo_data,       // Registered
    output logic       tx_fifo_wr_en,      // One cycle after byte_valid
    output logic       response_complete
);

    import frame_pkg::*;

    logic [7:0] crc_q;
    logic       crc_written;  // Last FIFO write carried the CRC

    // One byte through CRC-8 with MSB first
    function automatic logic [7:0] crc8_byte(input logic [7:0] crc_in, input logic [7:0] din);
        logic [7:0] c;
        c = crc_in ^ din;
        for (int i = 0; i < 8; i++) begin
            c = c[7] ? ((c << 1) ^ CRC_POLY) : (c << 1);
        end
        return c;
    endfunction

    // ------------------------------
    // CRC register
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || soft_reset_request || crc_clear) begin
            crc_q <= 8'h00;
        end else if (byte_valid && crc_include) begin
            crc_q <= crc8_byte(crc_q, byte_data);
        end
    end

    // ------------------------------
    // FIFO write port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            tx_fifo_data <= crc_send ? crc_q : byte_data;  // Frame byte or CRC register
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_reset_request) begin
            tx_fifo_wr_en     <= 1'b0;
            crc_written       <= 1'b0;
            response_complete <= 1'b0;
        end else begin
            tx_fifo_wr_en     <= byte_valid;
            crc_written       <= byte_valid && crc_send;
            response_complete <= crc_written;   // Cycle after the CRC write
        end
    end

endmodule

`default_nettype wire

/* hdl/frame_builder_top.sv */
`default_nettype none

module frame_builder_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            soft_reset_request,  // Abort and clear
    input  logic                            build_response,      // Rising edge starts a frame
    input  logic [7:0]                      status_code,
    input  frame_pkg::cmd_echo_t            cmd_echo,
    input  logic [8*frame_pkg::ADDR_BYTES-1:0] addr_echo,
    input  logic [7:0]                      response_data [0:frame_pkg::MAX_DATA_BYTES-1],
    input  logic [frame_pkg::DATA_COUNT_W-1:0] response_data_count,
    input  logic                            tx_fifo_full,        // Must rise with one slot left
    output logic [7:0]                      tx_fifo_data,
    output logic                            tx_fifo_wr_en,
    output logic                            builder_busy,
    output logic                            response_complete
);

    import frame_pkg::*;

    // Capture to sequencer
    logic                       frame_start;
    logic [7:0]                 status_q;
    cmd_echo_t                  cmd_q;
    logic [8*ADDR_BYTES-1:0]    addr_q;
    logic [DATA_COUNT_W-1:0]    count_q;
    logic [7:0]                 data_byte;
    logic [DATA_COUNT_W-1:0]    data_index;

    // Sequencer to emitter
    logic       byte_valid;
    logic [7:0] byte_data;
    logic       crc_include;
    logic       crc_send;
    logic       crc_clear;

    // ------------------------------
    // Input side
    // ------------------------------
    request_capture u_capture (
        .clk                 (clk),
        .rst                 (rst),
        .soft_reset_request  (soft_reset_request),
        .build_response      (build_response),
        .busy                (builder_busy),      // Blocks capture mid-frame
        .status_code         (status_code),
        .cmd_echo            (cmd_echo),
        .addr_echo           (addr_echo),
        .response_data       (response_data),
        .response_data_count (response_data_count),
        .data_index          (data_index),
        .frame_start         (frame_start),
        .status_q            (status_q),
        .cmd_q               (cmd_q),
        .addr_q              (addr_q),
        .count_q             (count_q),
        .data_byte           (data_byte)
    );

    frame_sequencer u_sequencer (
        .clk (clk), .rst (rst), .soft_reset_request (soft_reset_request),
        .frame_start (frame_start), .status_q (status_q), .cmd_q (cmd_q),
        .addr_q (addr_q), .count_q (count_q), .data_byte (data_byte),
        .tx_fifo_full (tx_fifo_full), .busy (builder_busy), .data_index (data_index),
        .byte_valid (byte_valid), .byte_data (byte_data), .crc_include (crc_include),
        .crc_send (crc_send), .crc_clear (crc_clear)
    );

    // Output side, FIFO port and completion
    frame_emitter u_emitter (
        .clk (clk), .rst (rst), .soft_reset_request (soft_reset_request),
        .byte_valid (byte_valid), .byte_data (byte_data), .crc_include (crc_include),
        .crc_send (crc_send), .crc_clear (crc_clear), .tx_fifo_data (tx_fifo_data),
        .tx_fifo_wr_en (tx_fifo_wr_en), .response_complete (response_complete)
    );

endmodule

`default_nettype wire

/* tests/frame_builder_asserts.sv */
`default_nettype none

module frame_builder_asserts (
    input logic clk,
    input logic rst,
    input logic soft_reset_request,
    input logic builder_busy,
    input logic frame_start,        // Internal capture pulse of the top level
    input logic tx_fifo_wr_en,
    input logic response_complete
);

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------
    // Output pulses
    // ------------------------------
    a_complete_single: assert property (
        @(posedge clk) disable iff (rst) response_complete |=> !response_complete
    ) else $error("response_complete high on two consecutive cycles");

    a_reset_quiet: assert property (@(posedge clk) rst |=> !tx_fifo_wr_en)
        else $error("tx_fifo_wr_en high in the cycle after rst");

    // ------------------------------
    // Frame starts only from idle
    // ------------------------------
    a_start_idle: assert property (
        @(posedge clk) disable iff (rst || soft_reset_request) frame_start |-> !builder_busy
    ) else $error("frame started while builder_busy");

    a_busy_blocks: assert property (
        @(posedge clk) disable iff (rst || soft_reset_request) builder_busy |=> !frame_start
    ) else $error("build_response accepted while builder_busy");

endmodule

bind frame_builder_top frame_builder_asserts u_asserts (
    .clk                (clk),
    .rst                (rst),
    .soft_reset_request (soft_reset_request),
    .builder_busy       (builder_busy),
    .frame_start        (frame_start),
    .tx_fifo_wr_en      (tx_fifo_wr_en),
    .response_complete  (response_complete)
);

`default_nettype wire

/* tests/frame_builder_tb.sv */
`default_nettype none

module frame_builder_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import frame_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int DRIVE_DELAY  = 5;   // Inputs change this long after the rising edge
    localparam int FIFO_DEPTH   = 8;   // TX FIFO model size
    // All frames below added up with the aborted one counted whole
    localparam int TOTAL_FRAME_BYTES = 447;
    localparam int TIMEOUT_CYCLES    = TOTAL_FRAME_BYTES * 8 + 2000;

    typedef logic [7:0] byte_q_t [$];

    // DUT ports
    logic                    clk;
    logic                    rst;
    logic                    soft_reset_request;
    logic                    build_response;
    logic [7:0]              status_code;
    cmd_echo_t               cmd_echo;
    logic [8*ADDR_BYTES-1:0] addr_echo;
    logic [7:0]              response_data [0:MAX_DATA_BYTES-1];
    logic [DATA_COUNT_W-1:0] response_data_count;
    logic                    tx_fifo_full = 1'b0;  // Owned by the FIFO model
    logic [7:0]              tx_fifo_data;
    logic                    tx_fifo_wr_en;
    logic                    builder_busy;
    logic                    response_complete;

    logic [31:0] data_seed = 32'd27;  // Data bytes and addresses
    logic [31:0] bp_seed   = 32'd27;  // Back-pressure and FIFO drain
    logic        bp_enable = 1'b0;
    byte_q_t     exp_q;               // Bytes still owed by the DUT
    int          fifo_level   = 0;
    int          complete_cnt = 0;
    int          cycle_cnt    = 0;

    frame_builder_top dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .soft_reset_request  (soft_reset_request),
        .build_response      (build_response),
        .status_code         (status_code),
        .cmd_echo            (cmd_echo),
        .addr_echo           (addr_echo),
        .response_data       (response_data),
        .response_data_count (response_data_count),
        .tx_fifo_full        (tx_fifo_full),
        .tx_fifo_data        (tx_fifo_data),
        .tx_fifo_wr_en       (tx_fifo_wr_en),
        .builder_busy        (builder_busy),
        .response_complete   (response_complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // CRC-8 one bit per step with feedback from MSB
    function automatic logic [7:0] crc8_ref(input logic [7:0] crc, input logic [7:0] d);
        logic [7:0] r;
        logic       fb;
        r = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = r[7] ^ d[i];
            r  = {r[6:0], 1'b0} ^ (fb ? CRC_POLY : 8'h00);
        end
        return r;
    endfunction

    function automatic byte_q_t frame_expect(input logic [7:0] status, input logic [7:0] cmd,
                                             input logic [31:0] addr,
                                             input logic [7:0] data [0:MAX_DATA_BYTES-1],
                                             input int count);
        byte_q_t    q;
        logic [7:0] crc;
        int         n;
        logic       ok;
        n  = (count > MAX_DATA_BYTES) ? MAX_DATA_BYTES : count;  // Saturated count
        ok = (status == STATUS_OK) || (status == STATUS_OK_ALT0) || (status == STATUS_OK_ALT1);
        q.push_back(SOF_DEVICE_TO_HOST);
        q.push_back(status);
        q.push_back(cmd);
        if (cmd != CMD_RESET) begin                  // RESET echo stops after CMD
            crc = crc8_ref(crc8_ref(8'h00, status), cmd);
            if (cmd[7] && ok) begin
                for (int i = 0; i < ADDR_BYTES; i++) begin
                    q.push_back(addr[8*i +: 8]);     // LSB first
                    crc = crc8_ref(crc, addr[8*i +: 8]);
                end
                for (int i = 0; i < n; i++) begin
                    q.push_back(data[i]);
                    crc = crc8_ref(crc, data[i]);
                end
            end
            q.push_back(crc);
        end
        return q;
    endfunction

    // ------------------------------
    // Checks and failure exits
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic stop_on_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "Run stopped");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            stop_on_failure("timeout, the frames did not finish in time");
        end
    end

    // Compare each FIFO write and model the FIFO level
    always @(posedge clk) begin
        if (tx_fifo_wr_en) begin
            if (exp_q.size() == 0) begin
                stop_on_failure("FIFO write while no byte was expected");
            end else begin
                check_value("tx_fifo_data", 32'(tx_fifo_data), 32'(exp_q.pop_front()));
                fifo_level++;
                if (fifo_level > FIFO_DEPTH) stop_on_failure("TX FIFO model overflowed");
            end
        end
        if (response_complete) complete_cnt++;
        bp_seed = lcg_next(bp_seed);
        if (fifo_level > 0 && (!bp_enable || bp_seed[20])) fifo_level--;  // Consumer side
        #DRIVE_DELAY;
        // Full with one slot left as a write may still be in flight
        tx_fifo_full = (fifo_level >= FIFO_DEPTH - 1) || (bp_enable && bp_seed[27]);
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic request_frame(input logic [7:0] status, input logic [7:0] cmd,
                                 input int count);
        byte_q_t frame;
        data_seed = lcg_next(data_seed);
        status_code         = status;
        cmd_echo.raw        = cmd;
        addr_echo           = data_seed;
        response_data_count = DATA_COUNT_W'(count);
        for (int i = 0; i < MAX_DATA_BYTES; i++) begin
            data_seed        = lcg_next(data_seed);
            response_data[i] = data_seed[23:16];
        end
        frame = frame_expect(status, cmd, addr_echo, response_data, count);
        foreach (frame[i]) exp_q.push_back(frame[i]);
        build_response = 1'b1;                       // Captured at the next edge
        @(posedge clk);
        #DRIVE_DELAY;
        build_response = 1'b0;
    endtask

    // Wait for the end of a frame and check it was whole
    task automatic finish_frame(input int completions);
        int start_cnt;
        start_cnt = complete_cnt;
        if (completions > 0) begin
            do @(posedge clk); while (!response_complete);
        end else begin
            do @(posedge clk); while (!builder_busy);
            do @(posedge clk); while (builder_busy);   // RESET echo ends here
        end
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        check_value("expected bytes left", 32'(exp_q.size()), 32'd0);
        check_value("response_complete pulses", 32'(complete_cnt - start_cnt), 32'(completions));
        check_value("builder_busy", 32'(builder_busy), 32'd0);
    endtask

    task automatic pulse_build_while_busy();
        do @(posedge clk); while (!builder_busy);
        repeat (10) @(posedge clk);
        #DRIVE_DELAY;
        status_code    = 8'h03;                      // Must not leak into the running frame
        addr_echo      = ~addr_echo;
        for (int i = 0; i < MAX_DATA_BYTES; i++) response_data[i] = ~response_data[i];
        build_response = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        build_response = 1'b0;
    endtask

    task automatic abort_frame_midway();
        int seen;
        int start_cnt;
        seen      = 0;
        start_cnt = complete_cnt;
        request_frame(8'h00, 8'h85, 64);
        while (seen < 20) begin
            @(posedge clk);
            if (tx_fifo_wr_en) seen++;
        end
        #DRIVE_DELAY;
        soft_reset_request = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        soft_reset_request = 1'b0;
        exp_q.delete();                              // Rest of the frame never comes
        check_value("builder_busy", 32'(builder_busy), 32'd0);
        check_value("tx_fifo_wr_en", 32'(tx_fifo_wr_en), 32'd0);
        repeat (8) @(posedge clk);                   // Stray writes hit the empty queue
        #DRIVE_DELAY;
        check_value("response_complete pulses", 32'(complete_cnt - start_cnt), 32'd0);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        rst                 = 1'b1;
        soft_reset_request  = 1'b0;
        build_response      = 1'b0;
        status_code         = 8'h00;
        cmd_echo            = '0;
        addr_echo           = '0;
        response_data_count = '0;
        for (int i = 0; i < MAX_DATA_BYTES; i++) response_data[i] = 8'h00;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        check_value("builder_busy", 32'(builder_busy), 32'd0);
        check_value("tx_fifo_wr_en", 32'(tx_fifo_wr_en), 32'd0);
        check_value("response_complete", 32'(response_complete), 32'd0);

        request_frame(8'h00, 8'h12, 0);              // Write ack
        finish_frame(1);
        request_frame(8'h40, 8'h85, 0);              // Reads of several lengths
        finish_frame(1);
        request_frame(8'h40, 8'h85, 1);
        finish_frame(1);
        request_frame(8'h40, 8'h85, 17);
        finish_frame(1);
        request_frame(8'h40, 8'h85, 64);
        finish_frame(1);
        request_frame(8'h40, 8'h85, 100);            // Clipped to 64
        finish_frame(1);
        request_frame(8'h03, 8'h85, 10);             // Read error without payload
        finish_frame(1);
        request_frame(8'h00, CMD_RESET, 8);
        finish_frame(0);

        bp_enable = 1'b1;
        request_frame(8'h80, 8'h91, 64);
        pulse_build_while_busy();
        finish_frame(1);
        request_frame(8'h80, 8'h91, 33);
        finish_frame(1);
        request_frame(8'h80, 8'h91, 5);
        finish_frame(1);
        request_frame(8'h00, 8'h20, 0);
        finish_frame(1);
        bp_enable = 1'b0;

        abort_frame_midway();
        request_frame(8'h00, 8'h85, 40);             // Clean frame after the abort
        finish_frame(1);

        if (exp_q.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Bytes still expected at the end of the run");
            $display("=== FAIL ===");
            $fatal(1, "Run stopped");
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/frame_pkg.sv
hdl/request_capture.sv
hdl/frame_sequencer.sv
hdl/frame_emitter.sv
hdl/frame_builder_top.sv
tests/frame_builder_asserts.sv
tests/frame_builder_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the frame builder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=frame_builder_sim

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module frame_builder_tb -f filelist.f -o "$BIN"
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi
exit 0
